// File: lsb_mem_top.f
hdl/lsb_pkg.sv
hdl/byte_ram.sv
hdl/load_store_queue.sv
hdl/fetch_queue.sv
hdl/mem_sequencer.sv
hdl/lsb_mem_top.sv
dv/lsb_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f lsb_mem_top.f --top-module lsb_mem_tb -o lsb_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/lsb_mem_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: dv/lsb_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsb_mem_tb;
    import lsb_pkg::*;

    localparam int    QUEUE_DEPTH  = 8;
    localparam int    RAM_BYTES    = 1024;
    localparam int    ADDR_W       = $clog2(RAM_BYTES);
    localparam word_t FETCH_BASE   = 32'h0000_0000; // Instruction words, never stored after init
    localparam word_t DATA_BASE    = 32'h0000_0100;
    localparam int    REGION_WORDS = 16;
    localparam int    MAX_OFFSET   = REGION_WORDS * 4 - 3; // A word stays inside its region
    localparam int    NUM_RANDOM   = 20;
    localparam int    CYCLES_PER_OP = 12;
    localparam int    TIMEOUT_CYCLES =
        (2 * REGION_WORDS + 2 * NUM_RANDOM + 30) * CYCLES_PER_OP + 100;

    logic     clk;
    logic     rst;
    mem_op_t  op;
    word_t    addr;
    word_t    data;
    rob_tag_t rob_number;
    rob_tag_t committed_number;
    logic     new_ins;
    word_t    pc_addr;
    rob_tag_t output_number;
    word_t    output_value;
    logic     mem_ready;
    word_t    ins_value;
    logic     ins_ready;
    logic     buffer_full;
    logic     if_full;

    integer   seed;
    byte_t    shadow [RAM_BYTES];
    int       check_errors = 0;
    int       other_errors = 0;
    int       ins_seen = 0;
    rob_tag_t last_tag = '0;

    // Expected memory results in queue order, and fetch words in PC order
    rob_tag_t exp_mem_tag [$];
    logic     exp_mem_load [$];
    word_t    exp_mem_val [$];
    int       exp_mem_ins [$]; // Fetch count required at the result, or -1
    word_t    exp_ins_val [$];

    rob_tag_t exp_tag;
    logic     exp_load;
    word_t    exp_val;
    int       exp_ins;

    lsb_mem_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RAM_BYTES   (RAM_BYTES)
    ) u_dut (
        .clk, .rst, .op, .addr, .data, .rob_number, .committed_number, .new_ins, .pc_addr,
        .output_number, .output_value, .mem_ready, .ins_value, .ins_ready, .buffer_full,
        .if_full
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////
    // Shadow memory model
    ////////////////////

    function automatic byte_t shadow_byte(word_t a);
        return shadow[ADDR_W'(a)];
    endfunction

    task automatic store_shadow(input mem_op_t kind, input word_t a, input word_t d);
        int n;
        case (kind)
            SB:      n = 1;
            SH:      n = 2;
            default: n = 4;
        endcase
        for (int k = 0; k < n; k++) begin
            shadow[ADDR_W'(a + word_t'(k))] = d[8*k +: 8]; // Byte k lands at address plus k
        end
    endtask

    function automatic word_t ref_load(mem_op_t kind, word_t a);
        byte_t b [4];
        for (int k = 0; k < 4; k++) begin
            b[k] = shadow_byte(a + word_t'(k));
        end
        case (kind)
            LB:      return {{24{b[0][7]}}, b[0]};
            LBU:     return {24'h000000, b[0]};
            LH:      return {{16{b[1][7]}}, b[1], b[0]};
            LHU:     return {16'h0000, b[1], b[0]};
            default: return {b[3], b[2], b[1], b[0]};
        endcase
    endfunction

    function automatic word_t ref_fetch(word_t pc);
        return {shadow_byte(pc + 32'd3), shadow_byte(pc + 32'd2),
                shadow_byte(pc + 32'd1), shadow_byte(pc)};
    endfunction

    ////////////////////
    // Stimulus helpers
    ////////////////////

    function automatic mem_op_t pick_load();
        case ($unsigned($random(seed)) % 5)
            0:       return LB;
            1:       return LH;
            2:       return LW;
            3:       return LBU;
            default: return LHU;
        endcase
    endfunction

    function automatic mem_op_t pick_store();
        case ($unsigned($random(seed)) % 3)
            0:       return SB;
            1:       return SH;
            default: return SW;
        endcase
    endfunction

    function automatic word_t rand_offset();
        return word_t'($unsigned($random(seed)) % MAX_OFFSET);
    endfunction

    task automatic alloc_tag(output rob_tag_t t);
        last_tag = (last_tag == 3'd7) ? 3'd1 : last_tag + 3'd1; // Zero is never a tag
        t = last_tag;
    endtask

    // Strobes last one cycle, from one falling edge to the next
    task automatic tick();
        @(negedge clk);
        op               = OP_NONE;
        committed_number = '0;
        new_ins          = 1'b0;
    endtask

    task automatic dispatch_op(input mem_op_t kind, input word_t a, input word_t d,
                               input rob_tag_t t, input int fetches_before);
        op         = kind;
        addr       = a;
        data       = d;
        rob_number = t;
        exp_mem_tag.push_back(t);
        exp_mem_ins.push_back(fetches_before);
        if (kind inside {SB, SH, SW}) begin
            store_shadow(kind, a, d);
            exp_mem_load.push_back(1'b0);
            exp_mem_val.push_back('0);
        end else begin
            exp_mem_load.push_back(1'b1);
            exp_mem_val.push_back(ref_load(kind, a));
        end
    endtask

    task automatic commit_tag(input rob_tag_t t);
        committed_number = t;
    endtask

    task automatic push_pc(input word_t pc);
        new_ins = 1'b1;
        pc_addr = pc;
        exp_ins_val.push_back(ref_fetch(pc));
    endtask

    task automatic wait_drained();
        while ((exp_mem_tag.size() != 0) || (exp_ins_val.size() != 0)) begin
            tick();
        end
    endtask

    task automatic run_one(input mem_op_t kind, input word_t a, input word_t d);
        rob_tag_t t;
        alloc_tag(t);
        tick();
        dispatch_op(kind, a, d, t, -1);
        tick();
        commit_tag(t);
        wait_drained();
    endtask

    ////////////////////
    // Result checker
    ////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            if (mem_ready || (output_number != '0)) begin
                if (exp_mem_tag.size() == 0) begin
                    other_errors++;
                    $display("Memory result with tag %0d at %0t was not expected",
                             output_number, $time);
                end else begin
                    exp_tag  = exp_mem_tag.pop_front();
                    exp_load = exp_mem_load.pop_front();
                    exp_val  = exp_mem_val.pop_front();
                    exp_ins  = exp_mem_ins.pop_front();
                    check_tag("output_number", output_number, exp_tag);
                    check_flag("mem_ready", mem_ready, exp_load);
                    if (exp_load) check_word("output_value", output_value, exp_val);
                    if ((exp_ins >= 0) && (ins_seen != exp_ins)) begin
                        other_errors++;
                        $display("Memory op with tag %0d finished after a later fetch at %0t",
                                 exp_tag, $time);
                    end
                end
            end
            if (ins_ready) begin
                ins_seen++;
                if (exp_ins_val.size() == 0) begin
                    other_errors++;
                    $display("Fetch result at %0t was not expected", $time);
                end else begin
                    check_word("ins_value", ins_value, exp_ins_val.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with results still outstanding", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin : stimulus
        rob_tag_t tags [6];
        rob_tag_t ta;
        rob_tag_t tb;
        rob_tag_t tc;
        word_t    a_st;
        seed             = 32'hb120_1b24;
        rst              = 1'b1;
        op               = OP_NONE;
        addr             = '0;
        data             = '0;
        rob_number       = '0;
        committed_number = '0;
        new_ins          = 1'b0;
        pc_addr          = '0;
        repeat (4) @(negedge clk);
        // Outputs straight out of reset, before any normal clock edge
        check_flag("mem_ready", mem_ready, 1'b0);
        check_flag("ins_ready", ins_ready, 1'b0);
        check_tag("output_number", output_number, '0);
        check_flag("buffer_full", buffer_full, 1'b0);
        check_flag("if_full", if_full, 1'b0);
        rst = 1'b0;
        tick();

        // Both regions get known contents before anything reads them
        for (int i = 0; i < REGION_WORDS; i++) begin
            run_one(SW, FETCH_BASE + word_t'(4 * i), word_t'($random(seed)));
            run_one(SW, DATA_BASE + word_t'(4 * i), word_t'($random(seed)));
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            case (i % 3)
                0:       run_one(SB, DATA_BASE + rand_offset(), word_t'($random(seed)));
                1:       run_one(SH, DATA_BASE + rand_offset(), word_t'($random(seed)));
                default: run_one(SW, DATA_BASE + rand_offset(), word_t'($random(seed)));
            endcase
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            case (i % 5)
                0:       run_one(LB, DATA_BASE + rand_offset(), '0);
                1:       run_one(LH, DATA_BASE + rand_offset(), '0);
                2:       run_one(LW, DATA_BASE + rand_offset(), '0);
                3:       run_one(LBU, DATA_BASE + rand_offset(), '0);
                default: run_one(LHU, DATA_BASE + rand_offset(), '0);
            endcase
        end

        // Uncommitted head blocks memory ops but not fetches
        alloc_tag(ta);
        alloc_tag(tb);
        tick();
        dispatch_op(pick_load(), DATA_BASE + rand_offset(), '0, ta, -1);
        for (int k = 0; k < 3; k++) begin
            tick();
            push_pc(FETCH_BASE + rand_offset());
        end
        tick();
        while (exp_ins_val.size() != 0) tick();
        repeat (20) tick();
        if (exp_mem_tag.size() != 1) begin
            other_errors++;
            $display("Load with tag %0d completed before its commit", ta);
        end
        dispatch_op(pick_store(), DATA_BASE + rand_offset(), word_t'($random(seed)), tb, -1);
        tick();
        commit_tag(tb); // Younger op committed first must still wait
        repeat (10) tick();
        if (exp_mem_tag.size() != 2) begin
            other_errors++;
            $display("Memory op passed an uncommitted head in the queue");
        end
        commit_tag(ta);
        wait_drained();

        // A committed op wins over fetches waiting at the next idle cycle
        alloc_tag(ta);
        alloc_tag(tb);
        a_st = DATA_BASE + rand_offset();
        tick();
        dispatch_op(SW, a_st, word_t'($random(seed)), ta, -1);
        tick();
        commit_tag(ta);
        dispatch_op(pick_load(), a_st, '0, tb, ins_seen);
        push_pc(FETCH_BASE + rand_offset());
        tick();
        commit_tag(tb);
        push_pc(FETCH_BASE + rand_offset());
        tick();
        push_pc(FETCH_BASE + rand_offset());
        wait_drained();

        for (int k = 0; k < 6; k++) begin
            tick();
            check_flag("buffer_full", buffer_full, 1'b0);
            alloc_tag(tags[k]);
            dispatch_op(pick_load(), DATA_BASE + rand_offset(), '0, tags[k], -1);
        end
        tick();
        check_flag("buffer_full", buffer_full, 1'b1);
        commit_tag(tags[0]);
        tick();
        while (!mem_ready) tick();
        check_flag("buffer_full", buffer_full, 1'b0);
        for (int k = 1; k < 6; k++) begin
            commit_tag(tags[k]);
            tick();
        end
        wait_drained();

        // Three committed stores keep the sequencer busy while PCs pile up
        alloc_tag(ta);
        alloc_tag(tb);
        alloc_tag(tc);
        tick();
        dispatch_op(SW, DATA_BASE + rand_offset(), word_t'($random(seed)), ta, -1);
        tick();
        dispatch_op(SW, DATA_BASE + rand_offset(), word_t'($random(seed)), tb, -1);
        commit_tag(ta);
        tick();
        dispatch_op(SW, DATA_BASE + rand_offset(), word_t'($random(seed)), tc, -1);
        commit_tag(tb);
        tick();
        commit_tag(tc);
        for (int k = 0; k < 6; k++) begin
            tick();
            check_flag("if_full", if_full, 1'b0);
            push_pc(FETCH_BASE + rand_offset());
        end
        tick();
        check_flag("if_full", if_full, 1'b1);
        while (!ins_ready) tick();
        check_flag("if_full", if_full, 1'b0);
        wait_drained();

        repeat (5) tick();
        $display("Value mismatches: %0d, other errors: %0d", check_errors, other_errors);
        if ((check_errors == 0) && (other_errors == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/lsb_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsb_mem_top #(
    parameter int QUEUE_DEPTH = 8,
    parameter int RAM_BYTES   = 1024
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire lsb_pkg::mem_op_t   op,
    input  wire lsb_pkg::word_t     addr,
    input  wire lsb_pkg::word_t     data,
    input  wire lsb_pkg::rob_tag_t  rob_number,
    input  wire lsb_pkg::rob_tag_t  committed_number,
    input  wire                     new_ins,
    input  wire lsb_pkg::word_t     pc_addr,
    output lsb_pkg::rob_tag_t       output_number,
    output lsb_pkg::word_t          output_value,
    output logic                    mem_ready,
    output lsb_pkg::word_t          ins_value,
    output logic                    ins_ready,
    output logic                    buffer_full,
    output logic                    if_full
);
    import lsb_pkg::*;

    logic     head_valid;
    logic     head_ready;
    mem_op_t  head_op;
    word_t    head_addr;
    word_t    head_data;
    rob_tag_t head_tag;
    logic     lsq_pop;
    logic     fetch_valid;
    word_t    fetch_pc;
    logic     fetch_pop;
    word_t    ram_addr;
    logic     ram_we;
    byte_t    ram_wdata;
    byte_t    ram_rdata;

    load_store_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_lsq (
        .clk, .rst, .op, .addr, .data, .rob_number, .committed_number, .lsq_pop,
        .head_valid, .head_ready, .head_op, .head_addr, .head_data, .head_tag,
        .buffer_full
    );

    fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_fetch_q (
        .clk, .rst, .new_ins, .pc_addr, .fetch_pop, .fetch_valid, .fetch_pc, .if_full
    );

    mem_sequencer u_seq (
        .clk, .rst, .head_valid, .head_ready, .head_op, .head_addr, .head_data,
        .head_tag, .fetch_valid, .fetch_pc, .ram_rdata, .lsq_pop, .fetch_pop,
        .ram_addr, .ram_we, .ram_wdata, .output_number, .output_value, .mem_ready,
        .ins_value, .ins_ready
    );

    byte_ram #(.RAM_BYTES(RAM_BYTES)) u_ram (
        .clk,
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: hdl/mem_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     head_valid,
    input  wire                     head_ready,
    input  wire lsb_pkg::mem_op_t   head_op,
    input  wire lsb_pkg::word_t     head_addr,
    input  wire lsb_pkg::word_t     head_data,
    input  wire lsb_pkg::rob_tag_t  head_tag,
    input  wire                     fetch_valid,
    input  wire lsb_pkg::word_t     fetch_pc,
    input  wire lsb_pkg::byte_t     ram_rdata,
    output logic                    lsq_pop,
    output logic                    fetch_pop,
    output lsb_pkg::word_t          ram_addr,
    output logic                    ram_we,
    output lsb_pkg::byte_t          ram_wdata,
    output lsb_pkg::rob_tag_t       output_number,
    output lsb_pkg::word_t          output_value,
    output logic                    mem_ready,
    output lsb_pkg::word_t          ins_value,
    output logic                    ins_ready
);
    import lsb_pkg::*;

    seq_state_t state;
    logic [1:0] idx;        // Byte being addressed
    logic [1:0] last_idx;   // Byte count minus one
    logic       job_fetch;
    word_t      job_addr;
    word_t      job_data;   // Store data, or bytes gathered by a load
    mem_op_t    job_op;
    rob_tag_t   job_tag;
    logic       head_go;
    logic       head_store;
    logic [1:0] head_last;
    word_t      load_word;
    word_t      load_ext;

    assign head_go = head_valid && head_ready; // Committed op beats fetch

    always_comb begin
        head_store = 1'b0;
        case (head_op)
            LB, LBU: head_last = 2'd0;
            LH, LHU: head_last = 2'd1;
            SB: begin
                head_store = 1'b1;
                head_last  = 2'd0;
            end
            SH: begin
                head_store = 1'b1;
                head_last  = 2'd1;
            end
            SW: begin
                head_store = 1'b1;
                head_last  = 2'd3;
            end
            default: head_last = 2'd3;
        endcase
    end

    ////////////////////
    // RAM side
    ////////////////////

    assign ram_addr  = job_addr + word_t'(idx); // Little endian, byte k at base plus k
    assign ram_we    = (state == STORE);
    assign ram_wdata = job_data[{idx, 3'b000} +: 8];

    // The queue that fed the job is popped in its final cycle
    assign lsq_pop   = ((state == STORE) && (idx == last_idx)) || ((state == WAIT) && !job_fetch);
    assign fetch_pop = (state == WAIT) && job_fetch;

    // Last byte arrives during WAIT
    always_comb begin
        load_word = job_data;
        load_word[{last_idx, 3'b000} +: 8] = ram_rdata;
    end

    always_comb begin
        case (job_op)
            LB:      load_ext = {{24{load_word[7]}}, load_word[7:0]};
            LBU:     load_ext = {24'h000000, load_word[7:0]};
            LH:      load_ext = {{16{load_word[15]}}, load_word[15:0]};
            LHU:     load_ext = {16'h0000, load_word[15:0]};
            default: load_ext = load_word;
        endcase
    end

    ////////////////////
    // FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            idx           <= '0;
            job_fetch     <= 1'b0;
            mem_ready     <= 1'b0;
            ins_ready     <= 1'b0;
            output_number <= '0;
        end else begin
            mem_ready     <= 1'b0;
            ins_ready     <= 1'b0;
            output_number <= '0;
            case (state)
                IDLE: begin
                    idx <= '0;
                    if (head_go) begin
                        state     <= head_store ? STORE : LOAD;
                        job_fetch <= 1'b0;
                    end else if (fetch_valid) begin
                        state     <= FETCH;
                        job_fetch <= 1'b1;
                    end
                end
                FETCH, LOAD: begin
                    if (idx == last_idx) state <= WAIT;
                    else idx <= idx + 2'd1;
                end
                STORE: begin
                    if (idx == last_idx) begin
                        state         <= IDLE;
                        output_number <= job_tag; // Store reports its tag only
                    end else begin
                        idx <= idx + 2'd1;
                    end
                end
                WAIT: begin
                    state <= IDLE;
                    if (job_fetch) begin
                        ins_ready <= 1'b1;
                    end else begin
                        mem_ready     <= 1'b1;
                        output_number <= job_tag;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && head_go) begin
            job_addr <= head_addr;
            job_data <= head_data;
            job_op   <= head_op;
            job_tag  <= head_tag;
            last_idx <= head_last;
        end else if (state == IDLE) begin
            job_addr <= fetch_pc;
            last_idx <= 2'd3;
        end
        // Byte from the previous address
        if (((state == LOAD) || (state == FETCH)) && (idx != 2'd0)) begin
            job_data[{idx - 2'd1, 3'b000} +: 8] <= ram_rdata;
        end
        if (state == WAIT) begin
            if (job_fetch) ins_value <= load_word;
            else output_value <= load_ext;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  new_ins,
    input  wire lsb_pkg::word_t  pc_addr,
    input  wire                  fetch_pop,
    output logic                 fetch_valid,
    output lsb_pkg::word_t       fetch_pc,
    output logic                 if_full
);
    import lsb_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] FULL_LEVEL = CNT_W'(QUEUE_DEPTH - 2);

    word_t            pc_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;

    assign count_next = count + CNT_W'(new_ins) - CNT_W'(fetch_pop);

    always_ff @(posedge clk) begin
        if (new_ins) begin
            pc_q[tail] <= pc_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            if_full <= 1'b0;
        end else begin
            if (new_ins) tail <= tail + PTR_W'(1);
            if (fetch_pop) head <= head + PTR_W'(1);
            count   <= count_next;
            if_full <= (count_next >= FULL_LEVEL); // Leaves room for two more PCs
        end
    end

    assign fetch_valid = (count != '0);
    assign fetch_pc    = pc_q[head];

endmodule

`default_nettype wire

// File: hdl/load_store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire lsb_pkg::mem_op_t    op,
    input  wire lsb_pkg::word_t      addr,
    input  wire lsb_pkg::word_t      data,
    input  wire lsb_pkg::rob_tag_t   rob_number,
    input  wire lsb_pkg::rob_tag_t   committed_number,
    input  wire                      lsq_pop,
    output logic                     head_valid,
    output logic                     head_ready,
    output lsb_pkg::mem_op_t         head_op,
    output lsb_pkg::word_t           head_addr,
    output lsb_pkg::word_t           head_data,
    output lsb_pkg::rob_tag_t        head_tag,
    output logic                     buffer_full
);
    import lsb_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] FULL_LEVEL = CNT_W'(QUEUE_DEPTH - 2);

    mem_op_t            op_q   [QUEUE_DEPTH];
    word_t              addr_q [QUEUE_DEPTH];
    word_t              data_q [QUEUE_DEPTH];
    rob_tag_t           tag_q  [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] valid_q;
    logic [QUEUE_DEPTH-1:0] ready_q;
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   count_next;
    logic               push;

    assign push = (op != OP_NONE);

    always_comb begin
        case ({push, lsq_pop})
            2'b10:   count_next = count + CNT_W'(1);
            2'b01:   count_next = count - CNT_W'(1);
            default: count_next = count;
        endcase
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (push) begin
            op_q[tail]   <= op;
            addr_q[tail] <= addr;
            data_q[tail] <= data;
            tag_q[tail]  <= rob_number;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q     <= '0;
            ready_q     <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            buffer_full <= 1'b0;
        end else begin
            // Commit marks every matching slot, the last one included
            if (committed_number != '0) begin
                for (int i = 0; i < QUEUE_DEPTH; i++) begin
                    if (valid_q[i] && (tag_q[i] == committed_number)) begin
                        ready_q[i] <= 1'b1;
                    end
                end
            end
            if (lsq_pop) begin
                valid_q[head] <= 1'b0;
                ready_q[head] <= 1'b0;
                head          <= head + PTR_W'(1);
            end
            if (push) begin
                valid_q[tail] <= 1'b1;
                ready_q[tail] <= 1'b0; // Waits for its commit
                tail          <= tail + PTR_W'(1);
            end
            count       <= count_next;
            buffer_full <= (count_next >= FULL_LEVEL);
        end
    end

    assign head_valid = valid_q[head];
    assign head_ready = ready_q[head];
    assign head_op    = op_q[head];
    assign head_addr  = addr_q[head];
    assign head_data  = data_q[head];
    assign head_tag   = tag_q[head];

endmodule

`default_nettype wire

// File: hdl/byte_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_ram #(
    parameter int RAM_BYTES = 1024
) (
    input  wire                  clk,
    input  wire lsb_pkg::word_t  addr,
    input  wire                  we,
    input  wire lsb_pkg::byte_t  wdata,
    output lsb_pkg::byte_t       rdata
);
    import lsb_pkg::*;

    localparam int ADDR_W = $clog2(RAM_BYTES);

    byte_t             mem [RAM_BYTES];
    logic [ADDR_W-1:0] index;

    assign index = addr[ADDR_W-1:0]; // Upper address bits wrap

    ////////////////////
    // Write at the edge, read registered
    ////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
        rdata <= mem[index];
    end

endmodule

`default_nettype wire

// File: hdl/lsb_pkg.sv
`default_nettype none

package lsb_pkg;

    ////////////////////
    // Data path widths
    ////////////////////

    typedef logic [31:0] word_t;    // Data and byte addresses
    typedef logic [7:0]  byte_t;    // RAM data path
    typedef logic [2:0]  rob_tag_t; // Zero means no tag

    ////////////////////
    // Memory op codes, same values as the core's decoder
    ////////////////////

    typedef enum logic [4:0] {
        LB      = 5'b10010,
        LH      = 5'b10011,
        LW      = 5'b10100,
        LBU     = 5'b10101,
        LHU     = 5'b10110,
        SB      = 5'b10111,
        SH      = 5'b11000,
        SW      = 5'b11001,
        OP_NONE = 5'b11111  // Nothing dispatched this cycle
    } mem_op_t;

    // Sequencer states
    // Three bits since five states are needed
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        LOAD,
        STORE,
        WAIT
    } seq_state_t;

endpackage

`default_nettype wire
